// ==== compile.f ====
+incdir+logic
logic/wb_data_pkg.sv
logic/wb_ctrl_pkg.sv
logic/wb_stage_ifs.sv
logic/wb_route.sv
logic/wb_redirect.sv
logic/wb_commit.sv
logic/writeback_top.sv
testbench/writeback_asserts.sv
testbench/writeback_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = writeback_tb
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== testbench/writeback_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module writeback_tb;

    localparam int HOLD_LIMIT = 20;                  // stalled cycles per row
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    typedef struct packed {
        logic       valid;
        logic [3:0] is_reg;
        logic [3:0] is_seg;
        logic [3:0] is_mem;
        logic [3:0] wb_en;
        logic [6:0] flags;                           // far halt taken correct odd ie intr
        logic [2:0] ie_type;
        logic       drain;
        logic [2:0] exp;                             // stall valid_out mem_ld
        logic [3:0] exp_reg_ld;
        logic [3:0] exp_seg_ld;
        logic       exp_halts;
    } row_t;

    logic clk, arst_n, valid_in, mem_drain;
    logic br_taken, br_correct, ie_in, interrupt_in;
    logic stall, valid_out, mem_ld, is_resteer, final_ie_val, halts;
    wb_ctrl_pkg::p_op_t p_op;
    wb_ctrl_pkg::ie_type_t ie_type_in, final_ie_type;
    wb_data_pkg::qword_t inp1, inp2, inp3, inp4;
    wb_data_pkg::qword_t res1, res2, res3, res4, mem_data;
    wb_data_pkg::word_t inp1_dest, inp2_dest, inp3_dest, inp4_dest;
    wb_data_pkg::word_t eip_in, br_fip, br_fip_p1;
    wb_data_pkg::word_t mem_addr, new_eip, new_fip_e, new_fip_o;
    wb_data_pkg::slot_mask_t is_reg, is_seg, is_mem, wb_en, reg_ld, seg_ld;
    wb_data_pkg::mem_size_t inp_size, ressize, memsize;
    wb_data_pkg::reg_idx_pack_t reg_addr, seg_addr;

    row_t        rows [16];
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          far_pick;

    writeback_top i_writeback_top (.*);

    bind writeback_top writeback_asserts i_asserts (
        .clk(clk), .arst_n(arst_n), .stall(stall), .valid_out(valid_out),
        .mem_ld(mem_ld), .reg_ld(reg_ld), .halts(halts));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic drive_row(row_t r);
        valid_in     = r.valid;
        mem_drain    = r.drain;
        is_reg       = r.is_reg;
        is_seg       = r.is_seg;
        is_mem       = r.is_mem;
        wb_en        = r.wb_en;
        p_op         = '0;
        if (r.flags[6]) begin
            case (far_pick)                          // walk all three far bits
                0:       p_op[`WB_POP_FAR_A] = 1'b1;
                1:       p_op[`WB_POP_FAR_B] = 1'b1;
                default: p_op[`WB_POP_FAR_C] = 1'b1;
            endcase
            far_pick = (far_pick + 1) % 3;
        end
        p_op[`WB_POP_HALT]  = r.flags[5];
        br_taken     = r.flags[4];
        br_correct   = r.flags[3];
        ie_in        = r.flags[1];
        interrupt_in = r.flags[0];
        ie_type_in   = {~r.flags[0], r.ie_type};    // bit 3 must be replaced
        inp1         = rand_bits(64);
        inp2         = rand_bits(64);
        inp3         = rand_bits(64);
        inp4         = rand_bits(64);
        inp1_dest    = 32'(rand_bits(32));
        inp2_dest    = 32'(rand_bits(32));
        inp3_dest    = 32'(rand_bits(32));
        inp4_dest    = 32'(rand_bits(32));
        eip_in       = 32'(rand_bits(32));
        br_fip       = 32'(rand_bits(32));
        br_fip_p1    = 32'(rand_bits(32));
        br_fip[`WB_FIP_PARITY_BIT] = r.flags[2];
        inp_size     = 2'(rand_bits(2));
    endtask

    task automatic check_outputs(row_t r);
        wb_data_pkg::slot_mask_t    st;
        wb_data_pkg::qword_t        exp_data;
        wb_data_pkg::word_t         exp_addr;
        wb_data_pkg::word_t         exp_eip;
        wb_data_pkg::word_t         line_a;
        wb_data_pkg::word_t         line_b;
        wb_data_pkg::reg_idx_pack_t exp_pack;
        logic                       far;
        far = r.flags[6];
        st  = r.is_mem & r.wb_en;
        check("valid_out", valid_out, r.exp[1]);
        check("reg_ld", reg_ld, r.exp_reg_ld);
        check("seg_ld", seg_ld, r.exp_seg_ld);
        check("mem_ld", mem_ld, r.exp[0]);
        check("halts", halts, r.exp_halts);
        check("is_resteer", is_resteer, r.exp[1] & ~r.flags[3]);
        check("final_ie_val", final_ie_val, r.exp[1] & (r.flags[1] | r.flags[0]));
        if (r.exp[1]) begin
            exp_data = st[0] ? inp1 : st[1] ? inp2 : st[2] ? inp3 : st[3] ? inp4 : '0;
            exp_addr = st[0] ? inp1_dest : st[1] ? inp2_dest :
                       st[2] ? inp3_dest : st[3] ? inp4_dest : '0;
            exp_eip  = !br_taken ? eip_in : (far ? inp1[31:0] : br_fip);
            line_a   = br_fip & ~32'hf;
            line_b   = br_fip_p1 & ~32'hf;
            exp_pack = {inp4_dest[2:0], inp3_dest[2:0], inp2_dest[2:0], inp1_dest[2:0]};
            check("reg_addr", reg_addr, exp_pack);
            check("seg_addr", seg_addr, exp_pack);
            check("res1", res1, far ? {48'd0, inp1[47:32]} : inp1);
            check("res2", res2, inp2);
            check("res3", res3, inp3);
            check("res4", res4, inp4);
            check("mem_data", mem_data, exp_data);
            check("mem_addr", mem_addr, exp_addr);
            check("ressize", ressize, inp_size);
            check("memsize", memsize, far ? 2'd3 : inp_size);
            check("new_eip", new_eip, exp_eip);
            check("new_fip_e", new_fip_e, br_fip[5] ? line_b : line_a);
            check("new_fip_o", new_fip_o, br_fip[5] ? line_a : line_b);
            check("final_ie_type", final_ie_type, {r.flags[0], r.ie_type});
        end
    endtask

    initial begin
        int waited;
        lfsr     = 32'd81;
        errors   = 0;
        checks   = 0;
        far_pick = 0;
        arst_n   = 1'b0;
        drive_row('0);
        // valid reg seg mem wb_en flags ie_type drain | exp reg_ld seg_ld halts
        rows[0]  = '{1'b1,4'hb,4'h4,4'h0,4'he,7'b0001000,3'd0,1'b0,3'b010,4'ha,4'h4,1'b0};
        rows[1]  = '{1'b1,4'hf,4'ha,4'h0,4'h5,7'b0011000,3'd0,1'b0,3'b010,4'h5,4'h0,1'b0};
        rows[2]  = '{1'b1,4'h0,4'h0,4'h6,4'hf,7'b0001000,3'd0,1'b0,3'b011,4'h0,4'h0,1'b0};
        rows[3]  = '{1'b1,4'h0,4'h0,4'hc,4'h8,7'b1011100,3'd0,1'b0,3'b011,4'h0,4'h0,1'b0};
        rows[4]  = '{1'b1,4'h1,4'h0,4'h0,4'h1,7'b0010100,3'd0,1'b0,3'b010,4'h1,4'h0,1'b0};
        rows[5]  = '{1'b1,4'h0,4'h0,4'h0,4'h0,7'b1001010,3'd5,1'b0,3'b010,4'h0,4'h0,1'b0};
        rows[6]  = '{1'b1,4'h0,4'h0,4'h0,4'h0,7'b1001001,3'd2,1'b0,3'b010,4'h0,4'h0,1'b0};
        rows[7]  = '{1'b1,4'h0,4'h0,4'h0,4'h0,7'b0001011,3'd7,1'b0,3'b010,4'h0,4'h0,1'b0};
        rows[8]  = '{1'b1,4'h0,4'h0,4'h1,4'h1,7'b0001000,3'd0,1'b0,3'b011,4'h0,4'h0,1'b0};
        rows[9]  = '{1'b1,4'h0,4'h0,4'h8,4'h8,7'b0001000,3'd0,1'b0,3'b011,4'h0,4'h0,1'b0};
        rows[10] = '{1'b1,4'h2,4'h0,4'h0,4'h2,7'b0001000,3'd0,1'b0,3'b010,4'h2,4'h0,1'b0};
        rows[11] = '{1'b1,4'h0,4'h0,4'h3,4'h3,7'b0001000,3'd0,1'b1,3'b111,4'h0,4'h0,1'b0};
        rows[12] = '{1'b0,4'h1,4'h1,4'h1,4'h1,7'b0001000,3'd0,1'b0,3'b000,4'h0,4'h0,1'b0};
        rows[13] = '{1'b1,4'h1,4'h0,4'h0,4'h1,7'b0101000,3'd0,1'b0,3'b010,4'h1,4'h0,1'b1};
        rows[14] = '{1'b1,4'hf,4'h0,4'h0,4'hf,7'b0001000,3'd0,1'b0,3'b000,4'h0,4'h0,1'b0};
        rows[15] = '{1'b1,4'h0,4'h0,4'h1,4'h1,7'b0001000,3'd0,1'b0,3'b000,4'h0,4'h0,1'b0};
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check("valid_out", valid_out, 1'b0);
        check("mem_ld", mem_ld, 1'b0);
        foreach (rows[i]) begin
            drive_row(rows[i]);
            #1;
            check("stall", stall, rows[i].exp[2]);
            waited = 0;
            while (stall && waited < HOLD_LIMIT) begin   // source holds the row
                @(negedge clk);
                mem_drain = 1'b0;
                waited++;
            end
            if (stall) begin
                errors++;
                $display("row %0d still stalled after %0d cycles", i, HOLD_LIMIT);
            end
            @(negedge clk);
            mem_drain = 1'b0;
            check_outputs(rows[i]);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/writeback_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module writeback_asserts (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    stall,
    input logic                    valid_out,
    input logic                    mem_ld,
    input wb_data_pkg::slot_mask_t reg_ld,
    input logic                    halts
);

    logic halted_seen;   // sticky once halts was seen

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted_seen <= 1'b0;
        end else if (halts) begin
            halted_seen <= 1'b1;
        end
    end

    stall_blocks_accept: assert property (@(posedge clk) disable iff (!arst_n)
        stall |=> !valid_out)
        else $error("valid_out set right after a stalled cycle");

    store_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
        mem_ld |-> valid_out)
        else $error("mem_ld without valid_out");

    reg_ld_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
        !valid_out |-> (reg_ld == '0))
        else $error("reg_ld set without valid_out");

    halt_is_final: assert property (@(posedge clk) disable iff (!arst_n)
        (halts || halted_seen) |=> !valid_out)
        else $error("instruction retired after halt");

endmodule

`default_nettype wire

// ==== logic/writeback_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module writeback_top #(
    parameter int MEMQ_DEPTH = `WB_MEMQ_DEPTH
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       valid_in,
    input  wb_ctrl_pkg::p_op_t         p_op,
    input  wb_data_pkg::qword_t        inp1,
    input  wb_data_pkg::qword_t        inp2,
    input  wb_data_pkg::qword_t        inp3,
    input  wb_data_pkg::qword_t        inp4,
    input  wb_data_pkg::word_t         inp1_dest,
    input  wb_data_pkg::word_t         inp2_dest,
    input  wb_data_pkg::word_t         inp3_dest,
    input  wb_data_pkg::word_t         inp4_dest,
    input  wb_data_pkg::slot_mask_t    is_reg,
    input  wb_data_pkg::slot_mask_t    is_seg,
    input  wb_data_pkg::slot_mask_t    is_mem,
    input  wb_data_pkg::slot_mask_t    wb_en,
    input  wb_data_pkg::mem_size_t     inp_size,
    input  wb_data_pkg::word_t         eip_in,
    input  wb_data_pkg::word_t         br_fip,
    input  wb_data_pkg::word_t         br_fip_p1,
    input  logic                       br_taken,
    input  logic                       br_correct,
    input  logic                       ie_in,
    input  logic                       interrupt_in,
    input  wb_ctrl_pkg::ie_type_t      ie_type_in,
    input  logic                       mem_drain,
    output logic                       stall,
    output logic                       valid_out,
    output wb_data_pkg::qword_t        res1,
    output wb_data_pkg::qword_t        res2,
    output wb_data_pkg::qword_t        res3,
    output wb_data_pkg::qword_t        res4,
    output wb_data_pkg::qword_t        mem_data,
    output wb_data_pkg::mem_size_t     ressize,
    output wb_data_pkg::mem_size_t     memsize,
    output wb_data_pkg::reg_idx_pack_t reg_addr,
    output wb_data_pkg::reg_idx_pack_t seg_addr,
    output wb_data_pkg::slot_mask_t    reg_ld,
    output wb_data_pkg::slot_mask_t    seg_ld,
    output logic                       mem_ld,
    output wb_data_pkg::word_t         mem_addr,
    output wb_data_pkg::word_t         new_eip,
    output wb_data_pkg::word_t         new_fip_e,
    output wb_data_pkg::word_t         new_fip_o,
    output logic                       is_resteer,
    output logic                       final_ie_val,
    output logic                       halts,
    output wb_ctrl_pkg::ie_type_t      final_ie_type
);

    wb_route_if    route_ch ();
    wb_redirect_if redir_ch ();

    wb_route i_route (
        .inp1      (inp1),
        .inp2      (inp2),
        .inp3      (inp3),
        .inp4      (inp4),
        .inp1_dest (inp1_dest),
        .inp2_dest (inp2_dest),
        .inp3_dest (inp3_dest),
        .inp4_dest (inp4_dest),
        .is_reg    (is_reg),
        .is_seg    (is_seg),
        .is_mem    (is_mem),
        .wb_en     (wb_en),
        .inp_size  (inp_size),
        .route     (route_ch.src)
    );

    wb_redirect i_redirect (
        .eip_in       (eip_in),
        .br_fip       (br_fip),
        .br_fip_p1    (br_fip_p1),
        .target_low   (inp1[31:0]),     // far target rides in slot 1
        .p_op         (p_op),
        .br_taken     (br_taken),
        .br_correct   (br_correct),
        .ie_in        (ie_in),
        .interrupt_in (interrupt_in),
        .ie_type_in   (ie_type_in),
        .redir        (redir_ch.src)
    );

    wb_commit #(
        .MEMQ_DEPTH (MEMQ_DEPTH)
    ) i_commit (
        .clk           (clk),
        .arst_n        (arst_n),
        .valid_in      (valid_in),
        .mem_drain     (mem_drain),
        .route         (route_ch.dst),
        .redir         (redir_ch.dst),
        .stall         (stall),
        .valid_out     (valid_out),
        .res1          (res1),
        .res2          (res2),
        .res3          (res3),
        .res4          (res4),
        .mem_data      (mem_data),
        .ressize       (ressize),
        .memsize       (memsize),
        .reg_addr      (reg_addr),
        .seg_addr      (seg_addr),
        .reg_ld        (reg_ld),
        .seg_ld        (seg_ld),
        .mem_ld        (mem_ld),
        .mem_addr      (mem_addr),
        .new_eip       (new_eip),
        .new_fip_e     (new_fip_e),
        .new_fip_o     (new_fip_o),
        .is_resteer    (is_resteer),
        .final_ie_val  (final_ie_val),
        .halts         (halts),
        .final_ie_type (final_ie_type)
    );

endmodule

`default_nettype wire

// ==== logic/wb_commit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module wb_commit #(
    parameter int MEMQ_DEPTH = `WB_MEMQ_DEPTH
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       valid_in,
    input  logic                       mem_drain,
    wb_route_if.dst                    route,
    wb_redirect_if.dst                 redir,
    output logic                       stall,
    output logic                       valid_out,
    output wb_data_pkg::qword_t        res1,
    output wb_data_pkg::qword_t        res2,
    output wb_data_pkg::qword_t        res3,
    output wb_data_pkg::qword_t        res4,
    output wb_data_pkg::qword_t        mem_data,
    output wb_data_pkg::mem_size_t     ressize,
    output wb_data_pkg::mem_size_t     memsize,
    output wb_data_pkg::reg_idx_pack_t reg_addr,
    output wb_data_pkg::reg_idx_pack_t seg_addr,
    output wb_data_pkg::slot_mask_t    reg_ld,
    output wb_data_pkg::slot_mask_t    seg_ld,
    output logic                       mem_ld,
    output wb_data_pkg::word_t         mem_addr,
    output wb_data_pkg::word_t         new_eip,
    output wb_data_pkg::word_t         new_fip_e,
    output wb_data_pkg::word_t         new_fip_o,
    output logic                       is_resteer,
    output logic                       final_ie_val,
    output logic                       halts,
    output wb_ctrl_pkg::ie_type_t      final_ie_type
);

    localparam int CNT_W = $clog2(MEMQ_DEPTH + 1);
    localparam logic [CNT_W-1:0] Q_FULL = CNT_W'(MEMQ_DEPTH);

    wb_ctrl_pkg::commit_state_e state;
    logic [CNT_W-1:0]           memq_cnt;
    logic                       running;
    logic                       has_store;
    logic                       accept;
    logic                       push;
    logic                       pop;

    assign running   = (state == wb_ctrl_pkg::CS_RUN);
    assign has_store = |route.mem_req;

    assign stall  = valid_in & has_store & (memq_cnt == Q_FULL) & running;
    assign accept = valid_in & ~stall & running;

    assign push = accept & has_store;
    assign pop  = mem_drain & (memq_cnt != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            memq_cnt <= '0;
        end else if (push && !pop) begin
            memq_cnt <= memq_cnt + 1'b1;
        end else if (pop && !push) begin
            memq_cnt <= memq_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= wb_ctrl_pkg::CS_RUN;
        end else if (accept && redir.halt_req) begin
            state <= wb_ctrl_pkg::CS_HALTED;   // stuck here until reset
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out    <= 1'b0;
            reg_ld       <= '0;
            seg_ld       <= '0;
            mem_ld       <= 1'b0;
            is_resteer   <= 1'b0;
            final_ie_val <= 1'b0;
            halts        <= 1'b0;
        end else begin
            valid_out    <= accept;
            reg_ld       <= accept ? route.reg_req : '0;
            seg_ld       <= accept ? route.seg_req : '0;
            mem_ld       <= push;
            is_resteer   <= accept & redir.resteer_req;
            final_ie_val <= accept & redir.ie_val;
            halts        <= accept & redir.halt_req;
        end
    end

    // payload holds its value between accepts
    always_ff @(posedge clk) begin
        if (accept) begin
            res1          <= redir.far_load ? {48'd0, route.res_raw1[47:32]} : route.res_raw1;
            res2          <= route.res_raw2;
            res3          <= route.res_raw3;
            res4          <= route.res_raw4;
            mem_data      <= route.mem_sel_data;
            mem_addr      <= route.mem_sel_addr;
            ressize       <= route.size;
            memsize       <= redir.far_load ? 2'b11 : route.size;   // far transfer
            reg_addr      <= route.reg_addr;
            seg_addr      <= route.reg_addr;
            new_eip       <= redir.new_eip;
            new_fip_e     <= redir.fip_e;
            new_fip_o     <= redir.fip_o;
            final_ie_type <= redir.ie_type;
        end
    end

endmodule

`default_nettype wire

// ==== logic/wb_redirect.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module wb_redirect (
    input  wb_data_pkg::word_t     eip_in,
    input  wb_data_pkg::word_t     br_fip,
    input  wb_data_pkg::word_t     br_fip_p1,
    input  wb_data_pkg::word_t     target_low,
    input  wb_ctrl_pkg::p_op_t     p_op,
    input  logic                   br_taken,
    input  logic                   br_correct,
    input  logic                   ie_in,
    input  logic                   interrupt_in,
    input  wb_ctrl_pkg::ie_type_t  ie_type_in,
    wb_redirect_if.src             redir
);

    logic               far_load;
    logic               odd_bank;
    wb_data_pkg::word_t taken_eip;
    wb_data_pkg::word_t line_a;
    wb_data_pkg::word_t line_b;

    assign far_load = p_op[`WB_POP_FAR_A] | p_op[`WB_POP_FAR_B] | p_op[`WB_POP_FAR_C];

    assign taken_eip = far_load ? target_low : br_fip;   // far jump takes inp1

    // line bases, offset cleared
    assign line_a = {br_fip[31:`WB_LINE_BITS], {`WB_LINE_BITS{1'b0}}};
    assign line_b = {br_fip_p1[31:`WB_LINE_BITS], {`WB_LINE_BITS{1'b0}}};

    assign odd_bank = br_fip[`WB_FIP_PARITY_BIT];

    assign redir.far_load    = far_load;
    assign redir.new_eip     = br_taken ? taken_eip : eip_in;
    assign redir.fip_e       = odd_bank ? line_b : line_a;
    assign redir.fip_o       = odd_bank ? line_a : line_b;
    assign redir.resteer_req = ~br_correct;                // mispredict
    assign redir.ie_val      = ie_in | interrupt_in;
    assign redir.ie_type     = {interrupt_in, ie_type_in[2:0]};
    assign redir.halt_req    = p_op[`WB_POP_HALT];

endmodule

`default_nettype wire

// ==== logic/wb_route.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module wb_route (
    input  wb_data_pkg::qword_t     inp1,
    input  wb_data_pkg::qword_t     inp2,
    input  wb_data_pkg::qword_t     inp3,
    input  wb_data_pkg::qword_t     inp4,
    input  wb_data_pkg::word_t      inp1_dest,
    input  wb_data_pkg::word_t      inp2_dest,
    input  wb_data_pkg::word_t      inp3_dest,
    input  wb_data_pkg::word_t      inp4_dest,
    input  wb_data_pkg::slot_mask_t is_reg,
    input  wb_data_pkg::slot_mask_t is_seg,
    input  wb_data_pkg::slot_mask_t is_mem,
    input  wb_data_pkg::slot_mask_t wb_en,
    input  wb_data_pkg::mem_size_t  inp_size,
    wb_route_if.src                 route
);

    wb_data_pkg::qword_t     slot_data [`WB_SLOTS];
    wb_data_pkg::word_t      slot_dest [`WB_SLOTS];
    wb_data_pkg::slot_mask_t mem_req;
    wb_data_pkg::qword_t     sel_data;
    wb_data_pkg::word_t      sel_addr;

    assign slot_data[0] = inp1;
    assign slot_data[1] = inp2;
    assign slot_data[2] = inp3;
    assign slot_data[3] = inp4;

    assign slot_dest[0] = inp1_dest;
    assign slot_dest[1] = inp2_dest;
    assign slot_dest[2] = inp3_dest;
    assign slot_dest[3] = inp4_dest;

    assign mem_req = is_mem & wb_en;

    // lowest slot wins, walked top down so it is written last
    always_comb begin
        sel_data = '0;
        sel_addr = '0;
        for (int i = `WB_SLOTS - 1; i >= 0; i--) begin
            if (mem_req[i]) begin
                sel_data = slot_data[i];
                sel_addr = slot_dest[i];
            end
        end
    end

    assign route.reg_req = is_reg & wb_en;
    assign route.seg_req = is_seg & wb_en;
    assign route.mem_req = mem_req;

    assign route.reg_addr = {inp4_dest[2:0], inp3_dest[2:0],
                             inp2_dest[2:0], inp1_dest[2:0]};   // slot 1 lowest

    assign route.mem_sel_data = sel_data;
    assign route.mem_sel_addr = sel_addr;

    assign route.res_raw1 = slot_data[0];
    assign route.res_raw2 = slot_data[1];
    assign route.res_raw3 = slot_data[2];
    assign route.res_raw4 = slot_data[3];
    assign route.size     = inp_size;

endmodule

`default_nettype wire

// ==== logic/wb_stage_ifs.sv ====
`timescale 1ns/1ns
`default_nettype none

interface wb_route_if;
    wb_data_pkg::slot_mask_t    reg_req;
    wb_data_pkg::slot_mask_t    seg_req;
    wb_data_pkg::slot_mask_t    mem_req;
    wb_data_pkg::reg_idx_pack_t reg_addr;
    wb_data_pkg::qword_t        mem_sel_data;    // chosen store payload
    wb_data_pkg::word_t         mem_sel_addr;
    wb_data_pkg::qword_t        res_raw1;
    wb_data_pkg::qword_t        res_raw2;
    wb_data_pkg::qword_t        res_raw3;
    wb_data_pkg::qword_t        res_raw4;
    wb_data_pkg::mem_size_t     size;

    modport src (output reg_req, seg_req, mem_req, reg_addr, mem_sel_data,
                 mem_sel_addr, res_raw1, res_raw2, res_raw3, res_raw4, size);
    modport dst (input reg_req, seg_req, mem_req, reg_addr, mem_sel_data,
                 mem_sel_addr, res_raw1, res_raw2, res_raw3, res_raw4, size);
endinterface

interface wb_redirect_if;
    logic                    far_load;           // eip and cs loaded together
    wb_data_pkg::word_t      new_eip;
    wb_data_pkg::word_t      fip_e;
    wb_data_pkg::word_t      fip_o;
    logic                    resteer_req;
    logic                    ie_val;
    wb_ctrl_pkg::ie_type_t   ie_type;
    logic                    halt_req;

    modport src (output far_load, new_eip, fip_e, fip_o, resteer_req,
                 ie_val, ie_type, halt_req);
    modport dst (input far_load, new_eip, fip_e, fip_o, resteer_req,
                 ie_val, ie_type, halt_req);
endinterface

`default_nettype wire

// ==== logic/wb_ctrl_pkg.sv ====
`default_nettype none

package wb_ctrl_pkg;

    typedef logic [36:0] p_op_t;                     // micro-op control flags

    // bit 3 marks an external interrupt
    typedef logic [3:0] ie_type_t;

    typedef enum logic {
        CS_RUN,
        CS_HALTED                                    // left only by reset
    } commit_state_e;

endpackage

`default_nettype wire

// ==== logic/wb_data_pkg.sv ====
`default_nettype none

`include "wb_params.svh"

package wb_data_pkg;

    typedef logic [31:0] word_t;                     // addresses, eip, fip
    typedef logic [63:0] qword_t;                    // slot results

    typedef logic [`WB_SLOTS-1:0] slot_mask_t;       // one flag per slot

    // 3-bit register index per slot, slot 1 lowest
    typedef logic [3*`WB_SLOTS-1:0] reg_idx_pack_t;

    typedef logic [1:0] mem_size_t;                  // operand size code

endpackage

`default_nettype wire

// ==== logic/wb_params.svh ====
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// result slots carried by one instruction
`define WB_SLOTS 4

`define WB_MEMQ_DEPTH 4      // stores waiting to drain

`define WB_LINE_BITS 4       // fetch-line offset
`define WB_FIP_PARITY_BIT 5  // even/odd line bank select

// p_op flag positions
`define WB_POP_HALT 9
`define WB_POP_FAR_A 36      // far load of eip and cs
`define WB_POP_FAR_B 35
`define WB_POP_FAR_C 32

`endif
